// ==== files.f ====
+incdir+verilog
verilog/rs_flow_pkg.sv
verilog/rs_xfer_pkg.sv
verilog/word_intake.sv
verilog/decode_sequencer.sv
verilog/word_output.sv
verilog/rs_main_control.sv
dv/tb_clock_gen.sv
dv/rs_main_control_tb.sv

// ==== Makefile ====
# Verilator build and run for the Reed-Solomon main controller

VERILATOR ?= verilator
TOP       ?= rs_main_control_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/rs_main_control_tb.sv ====
//************************************************************
// Reed-Solomon main controller testbench
// Runs random clean, error, failing and overlapped blocks
// against a cycle model of the controller
//************************************************************
`include "rs_ctrl_settings.svh"

module rs_main_control_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import rs_flow_pkg::*;
   import rs_xfer_pkg::*;

   // A block takes at most about 90 cycles
   localparam int NUM_BLOCKS   = 40;
   localparam int BLOCK_CYCLES = 90;
   localparam int MAX_CYCLES   = ((NUM_BLOCKS * BLOCK_CYCLES + 999) / 1000) * 1000;

   logic         clock1;
   logic         reset;
   logic         start;
   kes_status_t  kes;
   unit_enable_t units;
   logic         ready;
   logic         decode_fail;
   fifo_ctrl_t   fifo;
   out_status_t  out;

   // Model state
   flow_state_t  m_state;
   logic         m_err;
   logic         m_pend;
   logic         m_loaded;
   logic         m_en_prev;
   logic         m_held;
   logic         end_seen;
   int           in_left;
   int           win_left;

   // Expected outputs
   unit_enable_t exp_units;
   logic         exp_en_out;
   logic         exp_ready;
   fifo_ctrl_t   exp_fifo;
   out_status_t  exp_out;

   // Current block and run statistics
   logic blk_err;
   logic blk_match;
   logic blk_overlap;
   int   blk_lat;
   int   blk_delay;
   int   kes_cnt;
   int   out_cnt;
   int   cycles = 0;
   int   accepted = 0;
   int   errors = 0;
   int   other_fails = 0;
   int   fails_seen = 0;
   int   overlaps = 0;
   int   holds_seen = 0;
   int   ign_starts = 0;

   tb_clock_gen clock_gen_i (.clock1(clock1), .reset(reset));

   rs_main_control dut_i (
      .clock1      (clock1),
      .reset       (reset),
      .start       (start),
      .kes         (kes),
      .units       (units),
      .ready       (ready),
      .decode_fail (decode_fail),
      .fifo        (fifo),
      .out         (out)
   );

   always_comb begin
      exp_en_out = (m_state == OUTPUT) || (m_state == OUT_LOAD) || (m_state == OUT_BUSY);
      exp_ready  = !((m_state == SYND) || (m_state == KES_START) || (m_state == KES_WAIT) ||
                     (m_state == CSEE) || (m_state == OUT_BUSY));
      exp_units.active_sc   = (m_state == LOAD) || (m_state == OUT_LOAD);
      exp_units.active_kes  = (m_state == KES_START) || (m_state == KES_WAIT) ||
                              (m_state == CSEE) || (exp_en_out && m_err);
      exp_units.active_csee = (m_state == CSEE);
      exp_units.evalsynd    = (m_state == SYND);
      exp_units.errfound    = (m_state == KES_START);
      exp_out.dataoutstart  = (win_left == `RS_OUT_WORDS);
      exp_out.dataoutend    = end_seen;
      exp_out.lastdataout   = (win_left == 1);
      exp_out.evalerror     = (win_left > 0);
      exp_fifo.en_infifo    = (in_left > 0);
      exp_fifo.shift_fifo   = (in_left > 0) || (win_left > 0);
      exp_fifo.hold_fifo    = m_held && !exp_fifo.shift_fifo;
      exp_fifo.en_outfifo   = exp_en_out;
   end

   always @(posedge clock1 or negedge reset) begin : model_step
      flow_state_t nxt;
      flow_state_t after_out;
      logic        in_done;
      if (!reset) begin
         m_state   <= IDLE;
         m_err     <= 1'b0;
         m_pend    <= 1'b0;
         m_loaded  <= 1'b0;
         m_en_prev <= 1'b0;
         m_held    <= 1'b0;
         end_seen  <= 1'b0;
         in_left   <= 0;
         win_left  <= 0;
      end else begin
         in_done = (in_left == 1);
         if (m_err && (kes.lambda_degree != kes.rootcntr))
            after_out = FAIL;
         else
            after_out = m_pend ? WAIT_IN : IDLE;
         nxt = m_state;
         case (m_state)
            IDLE:      nxt = start ? LOAD : IDLE;
            LOAD:      nxt = WAIT_IN;
            WAIT_IN:   nxt = (in_done || m_loaded) ? SYND : WAIT_IN;
            SYND:      nxt = kes.errdetect ? KES_START : OUTPUT;
            KES_START: nxt = KES_WAIT;
            KES_WAIT:  nxt = kes.finish_kes ? CSEE : KES_WAIT;
            CSEE:      nxt = OUTPUT;
            OUTPUT:    nxt = end_seen ? after_out : (start ? OUT_LOAD : OUTPUT);
            OUT_LOAD:  nxt = end_seen ? after_out : OUT_BUSY;
            OUT_BUSY:  nxt = end_seen ? after_out : OUT_BUSY;
            FAIL:      nxt = m_pend ? WAIT_IN : (start ? LOAD : IDLE);
            default:   nxt = IDLE;
         endcase
         if (m_state == SYND)
            m_err <= kes.errdetect;
         if (m_state == OUTPUT && nxt == OUT_LOAD)
            m_pend <= 1'b1;
         else if (nxt == IDLE || nxt == LOAD || nxt == WAIT_IN)
            m_pend <= 1'b0;
         if (nxt == SYND)
            m_loaded <= 1'b0;
         else if (in_done)
            m_loaded <= 1'b1;
         // One block shifts in after each active_sc
         if (exp_units.active_sc)
            in_left <= `RS_BLOCK_WORDS;
         else if (in_left > 0)
            in_left <= in_left - 1;
         // Window opens the cycle after en_outfifo rises
         m_en_prev <= exp_en_out;
         end_seen  <= (win_left == 1);
         if (exp_en_out && !m_en_prev)
            win_left <= `RS_OUT_WORDS;
         else if (win_left > 0)
            win_left <= win_left - 1;
         if (in_done)
            m_held <= 1'b1;
         else if (exp_en_out && !m_en_prev)
            m_held <= 1'b0;
         m_state <= nxt;
      end
   end

   always @(posedge clock1) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         print_summary();
         $display("Test failures found");
         $finish;
      end
   end

   function automatic int pick_between(input int lo, input int hi);
      return lo + int'($urandom % (hi - lo + 1));
   endfunction

   task automatic compare_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic verify_outputs();
      compare_value("units", 8'(units), 8'(exp_units));
      compare_value("ready", 8'(ready), 8'(exp_ready));
      compare_value("decode_fail", 8'(decode_fail), 8'(m_state == FAIL));
      compare_value("fifo", 8'(fifo), 8'(exp_fifo));
      compare_value("out", 8'(out), 8'(exp_out));
      if (exp_fifo.en_infifo && exp_out.evalerror)
         overlaps++;
      if (exp_fifo.hold_fifo)
         holds_seen++;
      if (m_state == FAIL)
         fails_seen++;
   endtask

   // Plays the datapath and the block source from the model state
   task automatic drive_inputs();
      int                   r;
      logic [`RS_DEG_W-1:0] lam;
      r     = $urandom;
      start = 1'b0;
      kes.finish_kes = 1'b0;
      kes.errdetect  = r[8];
      case (m_state)
         IDLE, FAIL:
            if (!m_pend && accepted < NUM_BLOCKS && cycles > 8 && r[12])
               start = 1'b1;
         LOAD, OUT_LOAD:
            accepted++;
         SYND: begin
            blk_err       = r[16];
            blk_match     = r[17] | r[18];
            blk_overlap   = r[19] | r[20];
            blk_lat       = pick_between(1, 16);
            blk_delay     = pick_between(0, `RS_OUT_WORDS + 1);
            kes_cnt       = 0;
            out_cnt       = 0;
            kes.errdetect = blk_err;
         end
         KES_WAIT: begin
            kes_cnt++;
            kes.finish_kes = (kes_cnt == blk_lat);
         end
         OUTPUT: begin
            if (blk_overlap && out_cnt == blk_delay && accepted < NUM_BLOCKS)
               start = 1'b1;
            out_cnt++;
         end
         default: begin
         end
      endcase
      // Start while busy, which the DUT must ignore
      if (!exp_ready && r[23] && r[24]) begin
         start = 1'b1;
         ign_starts++;
      end
      lam = r[`RS_DEG_W-1:0];
      kes.lambda_degree = lam;
      kes.rootcntr      = blk_match ? lam : ~lam;
   endtask

   task automatic require_seen(input int count, input string what);
      if (count == 0) begin
         other_fails++;
         $display("Coverage gap: no %s during the run", what);
      end
   endtask

   task automatic print_summary();
      $display("Blocks %0d, cycles %0d, value errors %0d, other failures %0d",
               accepted, cycles, errors, other_fails);
   endtask

   initial begin
      start     = 1'b0;
      kes       = '0;
      blk_match = 1'b1;
      void'($urandom(4));
      @(posedge clock1);
      while (!(accepted == NUM_BLOCKS && m_state == IDLE && in_left == 0 && win_left == 0)) begin
         @(negedge clock1);
         verify_outputs();
         drive_inputs();
      end
      repeat (4) begin
         @(negedge clock1);
         verify_outputs();
      end
      require_seen(fails_seen, "decode failure");
      require_seen(overlaps, "overlapped load and readout");
      require_seen(holds_seen, "held block");
      require_seen(ign_starts, "start while busy");
      print_summary();
      if (errors == 0 && other_fails == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// ==== dv/tb_clock_gen.sv ====
//************************************************************
// Testbench clock and reset
// Makes clock1 with an 8 ns period and holds the active-low
// reset for the first three cycles
//************************************************************
module tb_clock_gen #(
   parameter real PERIOD       = 8.0,
   parameter int  RESET_CYCLES = 3
) (
   output logic clock1,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clock1 = 1'b0;
      forever #(PERIOD / 2.0) clock1 = ~clock1;
   end

   // Released on a falling edge, away from the DUT's sampling edge
   initial begin
      reset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock1);
      @(negedge clock1);
      reset = 1'b1;
   end

endmodule

// ==== verilog/rs_main_control.sv ====
//************************************************************
// Reed-Solomon decoder main controller
// Joins codeword intake, the decode sequencer and the
// corrected-word output so two codewords can be in flight
//************************************************************
module rs_main_control (
   input  logic                      clock1,
   input  logic                      reset,
   input  logic                      start,
   input  rs_flow_pkg::kes_status_t  kes,
   output rs_flow_pkg::unit_enable_t units,
   output logic                      ready,
   output logic                      decode_fail,
   output rs_xfer_pkg::fifo_ctrl_t   fifo,
   output rs_xfer_pkg::out_status_t  out
);

   logic in_shift;
   logic datain_done;
   logic en_outfifo;

   word_intake intake_i (
      .clock1      (clock1),
      .reset       (reset),
      .active_sc   (units.active_sc),
      .in_shift    (in_shift),
      .datain_done (datain_done)
   );

   decode_sequencer sequencer_i (
      .clock1      (clock1),
      .reset       (reset),
      .start       (start),
      .kes         (kes),
      .datain_done (datain_done),
      .dataoutend  (out.dataoutend),
      .units       (units),
      .en_outfifo  (en_outfifo),
      .ready       (ready),
      .decode_fail (decode_fail)
   );

   word_output output_i (
      .clock1      (clock1),
      .reset       (reset),
      .en_outfifo  (en_outfifo),
      .in_shift    (in_shift),
      .datain_done (datain_done),
      .fifo        (fifo),
      .out         (out)
   );

endmodule

// ==== verilog/word_output.sv ====
//************************************************************
// Corrected-word output
// Times the output window from the rising edge of the FIFO
// output enable and builds the FIFO control word
//************************************************************
`include "rs_ctrl_settings.svh"

module word_output (
   input  logic                     clock1,
   input  logic                     reset,
   input  logic                     en_outfifo,
   input  logic                     in_shift,
   input  logic                     datain_done,
   output rs_xfer_pkg::fifo_ctrl_t  fifo,
   output rs_xfer_pkg::out_status_t out
);
   import rs_xfer_pkg::*;

   localparam word_count_t LAST_SLOT = word_count_t'(`RS_OUT_WORDS - 1);

   logic        en_out_q;
   logic        window_start;
   logic        window_on;
   logic        window_end;
   logic        end_pulse;
   logic        block_held;
   word_count_t slot_cnt;

   assign window_start = en_outfifo && !en_out_q;
   assign window_end   = window_on && (slot_cnt == LAST_SLOT);

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         en_out_q   <= 1'b0;
         window_on  <= 1'b0;
         slot_cnt   <= '0;
         end_pulse  <= 1'b0;
      end else begin
         en_out_q  <= en_outfifo;
         end_pulse <= window_end;
         if (window_start) begin
            window_on <= 1'b1;
            slot_cnt  <= '0;
         end else if (window_end) begin
            window_on <= 1'b0;
            slot_cnt  <= '0;
         end else if (window_on) begin
            slot_cnt <= slot_cnt + 1'b1;
         end
      end
   end

   // Loaded block waiting for its own window
   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset)
         block_held <= 1'b0;
      else if (datain_done)
         block_held <= 1'b1;
      else if (window_start)
         block_held <= 1'b0;
   end

   always_comb begin
      out.dataoutstart = window_on && (slot_cnt == '0);
      out.dataoutend   = end_pulse;
      out.lastdataout  = window_end;
      out.evalerror    = window_on;
      fifo.shift_fifo  = in_shift || window_on;
      fifo.hold_fifo   = block_held && !(in_shift || window_on);
      fifo.en_infifo   = in_shift;
      fifo.en_outfifo  = en_outfifo;
   end

endmodule

// ==== verilog/decode_sequencer.sv ====
//************************************************************
// Decode sequencer
// Paces syndrome evaluation, the key-equation solver and the
// Chien search, and decides decode failure when each
// corrected-word window closes
//************************************************************
module decode_sequencer (
   input  logic                      clock1,
   input  logic                      reset,
   input  logic                      start,
   input  rs_flow_pkg::kes_status_t  kes,
   input  logic                      datain_done,
   input  logic                      dataoutend,
   output rs_flow_pkg::unit_enable_t units,
   output logic                      en_outfifo,
   output logic                      ready,
   output logic                      decode_fail
);
   import rs_flow_pkg::*;

   flow_state_t  state;
   flow_state_t  state_next;
   logic         err_path;
   logic         err_path_next;
   logic         next_pend;
   logic         in_loaded;
   logic         locator_bad;
   unit_enable_t units_next;
   logic         en_outfifo_next;
   logic         ready_next;
   logic         decode_fail_next;

   assign err_path_next = (state == SYND) ? kes.errdetect : err_path;

   // Locator degree must match the number of roots found
   assign locator_bad = err_path && (kes.lambda_degree != kes.rootcntr);

   always_comb begin
      flow_state_t done_state;
      if (locator_bad)
         done_state = FAIL;
      else if (next_pend)
         done_state = WAIT_IN;
      else
         done_state = IDLE;
      state_next = state;
      case (state)
         IDLE:
            if (start)
               state_next = LOAD;
         LOAD:
            state_next = WAIT_IN;
         WAIT_IN:
            if (datain_done || in_loaded)
               state_next = SYND;
         SYND:
            state_next = kes.errdetect ? KES_START : OUTPUT;
         KES_START:
            state_next = KES_WAIT;
         KES_WAIT:
            if (kes.finish_kes)
               state_next = CSEE;
         CSEE:
            state_next = OUTPUT;
         OUTPUT:
            if (dataoutend)
               state_next = done_state;
            else if (start)
               state_next = OUT_LOAD;
         OUT_LOAD:
            state_next = dataoutend ? done_state : OUT_BUSY;
         OUT_BUSY:
            if (dataoutend)
               state_next = done_state;
         FAIL:
            if (next_pend)
               state_next = WAIT_IN;
            else if (start)
               state_next = LOAD;
            else
               state_next = IDLE;
         default:
            state_next = IDLE;
      endcase
   end

   // Outputs of the state being entered
   always_comb begin
      units_next       = '0;
      en_outfifo_next  = 1'b0;
      ready_next       = 1'b1;
      decode_fail_next = 1'b0;
      case (state_next)
         LOAD:
            units_next.active_sc = 1'b1;
         SYND: begin
            units_next.evalsynd = 1'b1;
            ready_next          = 1'b0;
         end
         KES_START: begin
            units_next.errfound   = 1'b1;
            units_next.active_kes = 1'b1;
            ready_next            = 1'b0;
         end
         KES_WAIT: begin
            units_next.active_kes = 1'b1;
            ready_next            = 1'b0;
         end
         CSEE: begin
            units_next.active_kes  = 1'b1;
            units_next.active_csee = 1'b1;
            ready_next             = 1'b0;
         end
         OUTPUT: begin
            units_next.active_kes = err_path_next;
            en_outfifo_next       = 1'b1;
         end
         OUT_LOAD: begin
            units_next.active_sc  = 1'b1;
            units_next.active_kes = err_path_next;
            en_outfifo_next       = 1'b1;
         end
         OUT_BUSY: begin
            units_next.active_kes = err_path_next;
            en_outfifo_next       = 1'b1;
            ready_next            = 1'b0;
         end
         FAIL:
            decode_fail_next = 1'b1;
         default: begin
         end
      endcase
   end

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state       <= IDLE;
         err_path    <= 1'b0;
         units       <= '0;
         en_outfifo  <= 1'b0;
         ready       <= 1'b1;
         decode_fail <= 1'b0;
      end else begin
         state       <= state_next;
         err_path    <= err_path_next;
         units       <= units_next;
         en_outfifo  <= en_outfifo_next;
         ready       <= ready_next;
         decode_fail <= decode_fail_next;
      end
   end

   // A block accepted during output, and whether it has finished loading
   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         next_pend <= 1'b0;
         in_loaded <= 1'b0;
      end else begin
         if (state == OUTPUT && state_next == OUT_LOAD)
            next_pend <= 1'b1;
         else if (state_next inside {IDLE, LOAD, WAIT_IN})
            next_pend <= 1'b0;
         if (state_next == SYND)
            in_loaded <= 1'b0;
         else if (datain_done)
            in_loaded <= 1'b1;
      end
   end

endmodule

// ==== verilog/word_intake.sv ====
//************************************************************
// Codeword intake
// Shifts one block of words into the FIFO after each
// syndrome unit start and flags the last word
//************************************************************
`include "rs_ctrl_settings.svh"

module word_intake (
   input  logic clock1,
   input  logic reset,
   input  logic active_sc,
   output logic in_shift,
   output logic datain_done
);
   import rs_xfer_pkg::*;

   localparam word_count_t LAST_WORD = word_count_t'(`RS_BLOCK_WORDS - 1);

   word_count_t word_cnt;

   // Shifting begins the cycle after active_sc
   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         in_shift <= 1'b0;
         word_cnt <= '0;
      end else if (active_sc) begin
         in_shift <= 1'b1;
         word_cnt <= '0;
      end else if (datain_done) begin
         in_shift <= 1'b0;
         word_cnt <= '0;
      end else if (in_shift) begin
         word_cnt <= word_cnt + 1'b1;
      end
   end

   // High on the last word of the block
   assign datain_done = in_shift && (word_cnt == LAST_WORD);

endmodule

// ==== verilog/rs_xfer_pkg.sv ====
//************************************************************
// Word transfer types
// Word counter, codeword FIFO control and the status of the
// corrected-word output window
//************************************************************
`include "rs_ctrl_settings.svh"

package rs_xfer_pkg;

   typedef logic [`RS_CNT_W-1:0] word_count_t;

   // Control word for the codeword FIFO
   typedef struct packed {
      logic shift_fifo;
      logic hold_fifo;
      logic en_infifo;
      logic en_outfifo;
   } fifo_ctrl_t;

   typedef struct packed {
      logic dataoutstart;
      logic dataoutend;
      logic lastdataout;
      logic evalerror;
   } out_status_t;

endpackage

// ==== verilog/rs_flow_pkg.sv ====
//************************************************************
// Decode flow types
// Sequencer states, key-equation solver status and the
// enables sent to the syndrome, KES and CSEE units
//************************************************************
`include "rs_ctrl_settings.svh"

package rs_flow_pkg;

   typedef enum logic [3:0] {
      IDLE,
      LOAD,
      WAIT_IN,
      SYND,
      KES_START,
      KES_WAIT,
      CSEE,
      OUTPUT,
      OUT_LOAD,
      OUT_BUSY,
      FAIL
   } flow_state_t;

   // Status returned by the datapath
   typedef struct packed {
      logic                 errdetect;
      logic                 finish_kes;
      logic [`RS_DEG_W-1:0] lambda_degree;
      logic [`RS_DEG_W-1:0] rootcntr;
   } kes_status_t;

   typedef struct packed {
      logic active_sc;
      logic active_kes;
      logic active_csee;
      logic evalsynd;
      logic errfound;
   } unit_enable_t;

endpackage

// ==== verilog/rs_ctrl_settings.svh ====
//************************************************************
// Reed-Solomon main controller settings
// Block length, output window length and counter widths
// shared by the controller packages and sequencers
//************************************************************
`ifndef RS_CTRL_SETTINGS_SVH
`define RS_CTRL_SETTINGS_SVH

// Words per codeword loaded into the FIFO
`define RS_BLOCK_WORDS 31

// Output window, the block plus one evaluator pipeline slot
`define RS_OUT_WORDS 32

// Word counter width
`define RS_CNT_W 5

// Error locator degree and root count width
`define RS_DEG_W 3

`endif
